//--- design/trig_pattern_pkg.sv
`default_nettype none

package trig_pattern_pkg;

	// Bits per pattern word, and bit cycles per frame
	localparam int word_width = 8;

	// Bit counter width within one frame
	localparam int frame_count_width = 3;

	// Frames between two self-triggered words
	localparam int self_period_frames = 16;

	// Frame counter width for the self-trigger period
	localparam int period_count_width = $clog2(self_period_frames);

	// Number of words in one pattern sequence
	localparam int pattern_length = 4;

	// Pattern words in sending order, index 0 goes first
	// All of them have the top bit set so a receiver can find the start
	localparam logic [0:pattern_length-1][word_width-1:0] pattern_words = {
		8'b11110000,
		8'b10000001,
		8'b10001000,
		8'b10101010
	};

	// Sequencer token, names the word to be sent next
	typedef enum logic [1:0] {
		tok_first,
		tok_second,
		tok_third,
		tok_fourth
	} token_t;

	// One frame worth of output
	typedef struct packed {
		logic                  valid;
		logic [word_width-1:0] word;
	} frame_word_t;

	// Idle frame, nothing to send
	localparam frame_word_t idle_frame = '{
		valid: 1'b0,
		word:  '0
	};

endpackage

`default_nettype wire

//--- design/trigger_edge_detect.sv
`default_nettype none

module trigger_edge_detect (
	input  logic clock,
	input  logic reset1,
	input  logic trigger_in,
	input  logic frame_last,
	input  logic consume,
	output logic trigger_pending
);

	// Oldest sample in bit 2, newest in bit 0
	logic [2:0] trigger_stream;
	logic       rising;

	// Edge seen once the input has passed the first two stages
	assign rising = (trigger_stream[2:1] == 2'b01);

	always_ff @(posedge clock) begin
		if (reset1) begin
			trigger_stream <= '0;
		end else begin
			trigger_stream <= {trigger_stream[1:0], trigger_in};
		end
	end

	// A new edge wins over the clear at a boundary
	always_ff @(posedge clock) begin
		if (reset1) begin
			trigger_pending <= 1'b0;
		end else if (rising) begin
			trigger_pending <= 1'b1;
		end else if (frame_last && consume) begin
			trigger_pending <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- design/frame_timer.sv
`default_nettype none

module frame_timer (
	input  logic clock,
	input  logic reset1,
	output logic frame_last,
	output logic period_tick
);

	localparam logic [trig_pattern_pkg::frame_count_width-1:0] last_bit =
		trig_pattern_pkg::frame_count_width'(trig_pattern_pkg::word_width - 1);
	localparam logic [trig_pattern_pkg::period_count_width-1:0] last_frame =
		trig_pattern_pkg::period_count_width'(trig_pattern_pkg::self_period_frames - 1);

	logic [trig_pattern_pkg::frame_count_width-1:0]  bit_count;
	logic [trig_pattern_pkg::period_count_width-1:0] frame_count;

	// Final bit cycle of every frame
	assign frame_last = (bit_count == last_bit);

	// Final bit cycle of the last frame in the period
	assign period_tick = frame_last && (frame_count == last_frame);

	always_ff @(posedge clock) begin
		if (reset1) begin
			bit_count <= '0;
		end else if (frame_last) begin
			bit_count <= '0;
		end else begin
			bit_count <= bit_count + 1'b1;
		end
	end

	// Advances once per frame
	always_ff @(posedge clock) begin
		if (reset1) begin
			frame_count <= '0;
		end else if (period_tick) begin
			frame_count <= '0;
		end else if (frame_last) begin
			frame_count <= frame_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- design/pattern_sequencer.sv
`default_nettype none

module pattern_sequencer (
	input  logic                          clock,
	input  logic                          reset1,
	input  logic                          frame_last,
	input  logic                          self_triggered_mode,
	input  logic                          trigger_pending,
	input  logic                          period_tick,
	output logic                          consume,
	output trig_pattern_pkg::frame_word_t next_frame,
	output logic                          sync
);

	trig_pattern_pkg::token_t token;
	trig_pattern_pkg::token_t token_next;
	logic                     start;

	// Frame timer starts words in self-triggered mode, the trigger input otherwise
	assign start = self_triggered_mode ? period_tick : trigger_pending;

	// External requests are only used up in external mode
	assign consume = frame_last && !self_triggered_mode && trigger_pending;

	always_comb begin
		case (token)
			trig_pattern_pkg::tok_first:  token_next = trig_pattern_pkg::tok_second;
			trig_pattern_pkg::tok_second: token_next = trig_pattern_pkg::tok_third;
			trig_pattern_pkg::tok_third:  token_next = trig_pattern_pkg::tok_fourth;
			default:                      token_next = trig_pattern_pkg::tok_first;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset1) begin
			token <= trig_pattern_pkg::tok_first;
		end else if (frame_last && start) begin
			token <= token_next;
		end
	end

	// Word decided here goes out one frame later
	always_ff @(posedge clock) begin
		if (reset1) begin
			next_frame <= trig_pattern_pkg::idle_frame;
		end else if (frame_last) begin
			if (start) begin
				next_frame.valid <= 1'b1;
				next_frame.word  <= trig_pattern_pkg::pattern_words[token];
			end else begin
				next_frame <= trig_pattern_pkg::idle_frame;
			end
		end
	end

	// Sync rises with the first word and falls with the second
	always_ff @(posedge clock) begin
		if (reset1) begin
			sync <= 1'b0;
		end else if (frame_last && start) begin
			if (token == trig_pattern_pkg::tok_first) begin
				sync <= 1'b1;
			end else if (token == trig_pattern_pkg::tok_second) begin
				sync <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/word_serializer.sv
`default_nettype none

module word_serializer (
	input  logic                          clock,
	input  logic                          reset1,
	input  logic                          frame_last,
	input  trig_pattern_pkg::frame_word_t next_frame,
	output logic                          serial_out,
	output logic [7:0]                    led_word
);

	logic [trig_pattern_pkg::word_width-1:0] shift_reg;
	logic [trig_pattern_pkg::word_width-1:0] load_word;

	// Idle frames send zeros whatever the word field holds
	assign load_word = next_frame.valid ? next_frame.word : '0;

	// MSB first
	assign serial_out = shift_reg[trig_pattern_pkg::word_width-1];

	always_ff @(posedge clock) begin
		if (reset1) begin
			shift_reg <= '0;
		end else if (frame_last) begin
			shift_reg <= load_word;
		end else begin
			shift_reg <= {shift_reg[trig_pattern_pkg::word_width-2:0], 1'b0};
		end
	end

	// LEDs hold the word of the current frame
	always_ff @(posedge clock) begin
		if (reset1) begin
			led_word <= '0;
		end else if (frame_last) begin
			led_word <= load_word;
		end
	end

endmodule

`default_nettype wire

//--- design/trig_pattern_top.sv
`default_nettype none

module trig_pattern_top (
	input  logic       clock,
	input  logic       reset1,
	input  logic       trigger_in,
	input  logic       self_triggered_mode,
	output logic       serial_out,
	output logic       sync,
	output logic [7:0] led_word
);

	logic                          trigger_pending;
	logic                          consume;
	logic                          frame_last;
	logic                          period_tick;
	trig_pattern_pkg::frame_word_t next_frame;

	trigger_edge_detect trigger_edge_detect_i (
		.clock           (clock),
		.reset1          (reset1),
		.trigger_in      (trigger_in),
		.frame_last      (frame_last),
		.consume         (consume),
		.trigger_pending (trigger_pending)
	);

	frame_timer frame_timer_i (
		.clock       (clock),
		.reset1      (reset1),
		.frame_last  (frame_last),
		.period_tick (period_tick)
	);

	pattern_sequencer pattern_sequencer_i (
		.clock               (clock),
		.reset1              (reset1),
		.frame_last          (frame_last),
		.self_triggered_mode (self_triggered_mode),
		.trigger_pending     (trigger_pending),
		.period_tick         (period_tick),
		.consume             (consume),
		.next_frame          (next_frame),
		.sync                (sync)
	);

	word_serializer word_serializer_i (
		.clock      (clock),
		.reset1     (reset1),
		.frame_last (frame_last),
		.next_frame (next_frame),
		.serial_out (serial_out),
		.led_word   (led_word)
	);

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
	output logic clock,
	output logic reset1
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int half_period = 4;
	localparam int reset_cycles = 3;

	initial begin
		clock = 1'b0;
		forever #half_period clock = ~clock;
	end

	// Reset leaves on a falling edge, away from the DUT sampling edge
	initial begin
		reset1 = 1'b1;
		repeat (reset_cycles) @(posedge clock);
		@(negedge clock);
		reset1 = 1'b0;
	end

endmodule

`default_nettype wire

//--- dv/trig_pattern_tb.sv
`default_nettype none

module trig_pattern_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int frame_cycles = 8;
	localparam int period_cycles = 16 * frame_cycles;
	localparam int reset_cycles = 3;
	localparam int quiet_cycles = 24;
	localparam int min_spacing = 24;
	localparam int max_spacing = 39;
	localparam int row_count = 5;

	// Zero spacing means a random spacing per pulse
	typedef struct packed {
		logic        self_mode;
		logic        reset_first;
		logic [7:0]  pulses;
		logic [7:0]  spacing;
		logic [7:0]  words;
		logic [15:0] idle;
	} stim_row_t;

	logic       clock;
	logic       gen_reset;
	logic       tb_reset;
	logic       reset1;
	logic       trigger_in;
	logic       self_triggered_mode;
	logic       serial_out;
	logic       sync;
	logic [7:0] led_word;

	logic [7:0] expected_words [0:3];
	stim_row_t  stim_table [0:row_count-1];

	integer     seed;
	int         run_cycles;
	int         since_reset;
	int         cycle_limit;
	int         words_seen;
	int         model_token;
	logic       model_sync;
	logic       collecting;
	int         bit_index;
	logic [7:0] shift_word;
	logic [7:0] led_at_start;
	int         start_cycle;
	int         prev_start;
	logic       have_prev;
	logic       gap_check_on;

	assign reset1 = gen_reset | tb_reset;

	tb_clock_gen clock_gen_i (
		.clock  (clock),
		.reset1 (gen_reset)
	);

	trig_pattern_top trig_pattern_top_i (
		.clock               (clock),
		.reset1              (reset1),
		.trigger_in          (trigger_in),
		.self_triggered_mode (self_triggered_mode),
		.serial_out          (serial_out),
		.sync                (sync),
		.led_word            (led_word)
	);

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Mismatch at %0d ns: %s is %0h, expected %0h", $time, name, actual, expected);
			$display("Test failures found");
			$fatal(1);
		end
	endtask

	always @(posedge clock) begin
		run_cycles = run_cycles + 1;
		if (run_cycles > cycle_limit) begin
			$display("Timeout: the DUT did not send the expected words within %0d cycles",
				cycle_limit);
			$display("Test failures found");
			$fatal(1);
		end
	end

	// Bit cycle counter of the frame timer, rebuilt from the reset release
	always @(posedge clock) begin
		if (reset1) begin
			since_reset = 0;
		end else begin
			since_reset = since_reset + 1;
		end
	end

	// Word order, sync level and self-triggered spacing
	task automatic record_word(input logic [7:0] word, input int first_cycle);
		check_value("serial word", word, expected_words[model_token]);
		check_value("led_word", led_at_start, word);
		if (model_token == 0) begin
			model_sync = 1'b1;
		end else if (model_token == 1) begin
			model_sync = 1'b0;
		end
		check_value("sync", sync, model_sync);
		if (gap_check_on && have_prev) begin
			check_value("self word gap", first_cycle - prev_start, period_cycles);
		end
		prev_start = first_cycle;
		have_prev = gap_check_on;
		model_token = (model_token + 1) % 4;
		words_seen = words_seen + 1;
	endtask

	// Every word starts with a 1, so a set bit marks the frame start
	always @(negedge clock) begin
		if (!collecting) begin
			if (serial_out === 1'b1) begin
				collecting = 1'b1;
				bit_index = 1;
				shift_word = 8'h01;
				led_at_start = led_word;
				start_cycle = run_cycles;
			end
		end else begin
			shift_word = {shift_word[6:0], serial_out};
			bit_index = bit_index + 1;
			check_value("led_word", led_word, led_at_start);
			if (bit_index == 8) begin
				collecting = 1'b0;
				record_word(shift_word, start_cycle);
			end
		end
	end

	task automatic load_table();
		stim_table[0] = '{self_mode: 1'b0, reset_first: 1'b0, pulses: 8'd5, spacing: 8'd0,
			words: 8'd5, idle: 16'd32};
		stim_table[1] = '{self_mode: 1'b0, reset_first: 1'b0, pulses: 8'd1, spacing: 8'd0,
			words: 8'd1, idle: 16'd32};
		// Two pulses inside one frame merge into one word
		stim_table[2] = '{self_mode: 1'b0, reset_first: 1'b0, pulses: 8'd2, spacing: 8'd3,
			words: 8'd1, idle: 16'd32};
		stim_table[3] = '{self_mode: 1'b1, reset_first: 1'b0, pulses: 8'd0, spacing: 8'd0,
			words: 8'd4, idle: 16'd16};
		stim_table[4] = '{self_mode: 1'b0, reset_first: 1'b1, pulses: 8'd2, spacing: 8'd0,
			words: 8'd2, idle: 16'd32};
	endtask

	function automatic int row_budget(input stim_row_t row);
		int budget;
		budget = int'(row.idle) + 4 * frame_cycles;
		if (row.reset_first) begin
			budget = budget + reset_cycles;
		end
		if (row.self_mode) begin
			budget = budget + (int'(row.words) + 1) * period_cycles;
		end else begin
			budget = budget + int'(row.pulses) * (max_spacing + 1) + frame_cycles;
		end
		return budget;
	endfunction

	task automatic apply_reset();
		tb_reset = 1'b1;
		repeat (reset_cycles) @(negedge clock);
		tb_reset = 1'b0;
		model_token = 0;
		model_sync = 1'b0;
		@(negedge clock);
		check_value("sync", sync, 0);
		check_value("led_word", led_word, 0);
	endtask

	// Edges sampled at frame cycles 6 and 1 both reach the same boundary
	task automatic align_to_frame();
		while (since_reset % frame_cycles != 5) @(negedge clock);
	endtask

	task automatic run_row(input stim_row_t row);
		int target;
		int gap;
		@(posedge clock);
		target = words_seen + int'(row.words);
		gap_check_on = row.self_mode;
		have_prev = 1'b0;
		@(negedge clock);
		self_triggered_mode = row.self_mode;
		if (row.reset_first) begin
			apply_reset();
		end
		if (row.spacing != 0) begin
			align_to_frame();
		end
		for (int i = 0; i < int'(row.pulses); i++) begin
			if (row.spacing == 0) begin
				gap = min_spacing + ($random(seed) & 15);
			end else begin
				gap = int'(row.spacing);
			end
			trigger_in = 1'b1;
			@(negedge clock);
			trigger_in = 1'b0;
			repeat (gap - 1) @(negedge clock);
		end
		while (words_seen < target) @(posedge clock);
		repeat (int'(row.idle)) @(negedge clock);
		@(posedge clock);
		check_value("word count", words_seen, target);
	endtask

	initial begin : main_sequence
		int total;
		seed = 32'hed73_3555;
		trigger_in = 1'b0;
		self_triggered_mode = 1'b0;
		tb_reset = 1'b0;
		run_cycles = 0;
		since_reset = 0;
		words_seen = 0;
		model_token = 0;
		model_sync = 1'b0;
		collecting = 1'b0;
		bit_index = 0;
		have_prev = 1'b0;
		gap_check_on = 1'b0;
		expected_words[0] = 8'b11110000;
		expected_words[1] = 8'b10000001;
		expected_words[2] = 8'b10001000;
		expected_words[3] = 8'b10101010;
		load_table();
		total = reset_cycles + quiet_cycles;
		for (int r = 0; r < row_count; r++) begin
			total = total + row_budget(stim_table[r]);
		end
		cycle_limit = 2 * total;

		// Quiet outputs through reset and with no start
		repeat (reset_cycles + quiet_cycles) begin
			@(negedge clock);
			check_value("serial_out", serial_out, 0);
			check_value("sync", sync, 0);
			check_value("led_word", led_word, 0);
		end
		check_value("word count", words_seen, 0);

		for (int r = 0; r < row_count; r++) begin
			run_row(stim_table[r]);
		end
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
design/trig_pattern_pkg.sv
design/trigger_edge_detect.sv
design/frame_timer.sv
design/pattern_sequencer.sv
design/word_serializer.sv
design/trig_pattern_top.sv
dv/tb_clock_gen.sv
dv/trig_pattern_tb.sv

//--- Bender.yml
package:
  name: trig_pattern

sources:
  - files:
      - design/trig_pattern_pkg.sv
      - design/trigger_edge_detect.sv
      - design/frame_timer.sv
      - design/pattern_sequencer.sv
      - design/word_serializer.sv
      - design/trig_pattern_top.sv

  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/trig_pattern_tb.sv
